// File: all.f
hdl/ahb_pkg.sv
hdl/comp_pkg.sv
hdl/block_sequencer.sv
hdl/ahb_burst_master.sv
hdl/beat_packer.sv
hdl/result_select.sv
hdl/comp_engine_top.sv
tests/tb_clock_gen.sv
tests/comp_engine_tb.sv

// File: Bender.yml
package:
  name: comp_engine

sources:
  - hdl/ahb_pkg.sv
  - hdl/comp_pkg.sv
  - hdl/block_sequencer.sv
  - hdl/ahb_burst_master.sv
  - hdl/beat_packer.sv
  - hdl/result_select.sv
  - hdl/comp_engine_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/comp_engine_tb.sv

// File: tests/comp_engine_tb.sv
module comp_engine_tb
    import ahb_pkg::*;
    import comp_pkg::*;
();

    localparam int NUM_COMP    = 3;
    localparam int BLK_CNT_W   = 25;
    localparam int MEM_WORDS   = 4096;
    localparam int NUM_TESTS   = 10;
    localparam int BLK_TIMEOUT = 1000;
    localparam int MAX_LINES   = 6;

    typedef struct packed {
        logic [31:0]          src;
        logic [31:0]          dst;
        logic [BLK_CNT_W-1:0] len;
        logic [NUM_COMP-1:0]  fail;
        logic                 stall;
    } test_row_t;

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    logic                      done;
    logic [31:0]               src_addr;
    logic [31:0]               dst_addr;
    logic [BLK_CNT_W-1:0]      len;
    ahb_req_t                  ahb_req;
    ahb_rsp_t                  ahb_rsp;
    comp_word_t                comp_word;
    logic [NUM_COMP-1:0]       comp_done;
    logic [NUM_COMP-1:0]       comp_fail;
    logic [BUF_ADDR_W-1:0]     buf_addr;
    logic [NUM_COMP-1:0][63:0] comp_rdata;

    // memory, its copy before each test, and the expected image
    logic [31:0] mem     [MEM_WORDS];
    logic [31:0] snap    [MEM_WORDS];
    logic [31:0] exp_mem [MEM_WORDS];

    test_row_t   rows  [NUM_TESTS];
    string       names [NUM_TESTS];
    int          num_rows;
    string       cur_name;
    int          errors;
    int          test_errs;
    int          err_lines;
    bit          timed_out;
    bit          stall_en;
    bit          req_seen;
    int          range_errs;
    int          blocks_seen;
    int          comp_blk;
    logic [63:0] rec_data [$];
    logic        rec_sop  [$];
    logic        rec_eop  [$];

    tb_clock_gen #(.PERIOD(4)) u_clk (.clk_o(clk));

    comp_engine_top #(
        .NUM_COMP  (NUM_COMP),
        .BLK_CNT_W (BLK_CNT_W)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .done_o       (done),
        .src_addr_i   (src_addr),
        .dst_addr_i   (dst_addr),
        .len_i        (len),
        .ahb_o        (ahb_req),
        .ahb_i        (ahb_rsp),
        .comp_o       (comp_word),
        .comp_done_i  (comp_done),
        .comp_fail_i  (comp_fail),
        .buf_addr_o   (buf_addr),
        .comp_rdata_i (comp_rdata)
    );

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[13:2]);
    endfunction

    // result buffer contents per compressor, block and entry
    function automatic logic [63:0] buf_word(input int c, input int b, input logic [2:0] a);
        logic [7:0] cb;
        logic [7:0] bb;
        logic [7:0] ab;
        cb = 8'(c);
        bb = 8'(b);
        ab = 8'(a);
        return {8'hc0 | cb, bb, ab, 8'h5a, ~cb, bb ^ 8'h3c, ab ^ 8'ha5, cb + bb + ab};
    endfunction

    // lowest compressor that passed, else 0
    function automatic int owner_of(input logic [NUM_COMP-1:0] fail);
        int own;
        own = -1;
        for (int c = 0; c < NUM_COMP; c++) begin
            if (!fail[c] && own < 0) begin
                own = c;
            end
        end
        return (own < 0) ? 0 : own;
    endfunction

    for (genvar c = 0; c < NUM_COMP; c++) begin : g_buf
        assign comp_rdata[c] = buf_word(c, comp_blk, buf_addr);
    end

    // ------------------------------------------------------------
    // AHB slave, arbiter and compressor models
    // ------------------------------------------------------------
    // sampled on the falling edge, driven 1 unit after the rising edge
    initial begin : bus_and_comp_model
        logic                dp_valid;
        logic                dp_write;
        logic [31:0]         dp_addr;
        logic                rdy_nxt;
        logic                gnt_nxt;
        int                  gnt_wait;
        int                  done_cnt [NUM_COMP];
        logic [NUM_COMP-1:0] done_nxt;
        dp_valid = 1'b0;
        dp_write = 1'b0;
        dp_addr  = '0;
        gnt_nxt  = 1'b0;
        gnt_wait = 0;
        done_nxt = '0;
        for (int c = 0; c < NUM_COMP; c++) begin
            done_cnt[c] = 0;
        end
        ahb_rsp   = '0;
        ahb_rsp.hready = 1'b1;
        comp_done = '0;
        forever begin
            @(negedge clk);
            if (ahb_rsp.hready) begin
                // data phase completes, next address phase moves in
                if (dp_valid && dp_write) begin
                    mem[word_index(dp_addr)] = ahb_req.hwdata;
                end
                dp_valid = (ahb_req.htrans == HTRANS_NONSEQ) || (ahb_req.htrans == HTRANS_SEQ);
                dp_write = ahb_req.hwrite;
                dp_addr  = ahb_req.haddr;
                if (dp_valid && dp_addr[31:14] != '0) begin
                    range_errs++;
                end
            end
            if (ahb_req.hbusreq) begin
                req_seen = 1'b1;
                if (gnt_wait > 0) begin
                    gnt_wait--;
                end else begin
                    gnt_nxt = 1'b1;
                end
            end else begin
                gnt_nxt  = 1'b0;
                gnt_wait = stall_en ? int'($urandom % 6) : 0;
            end
            rdy_nxt = stall_en ? ($urandom % 4 != 0) : 1'b1;
            if (comp_word.wren) begin
                rec_data.push_back(comp_word.data);
                rec_sop.push_back(comp_word.sop);
                rec_eop.push_back(comp_word.eop);
                if (comp_word.sop) begin
                    comp_blk = blocks_seen;
                    blocks_seen++;
                    done_nxt = '0;
                    for (int c = 0; c < NUM_COMP; c++) begin
                        done_cnt[c] = 0;
                    end
                end
                if (comp_word.eop) begin
                    for (int c = 0; c < NUM_COMP; c++) begin
                        done_cnt[c] = 1 + int'($urandom % 6);
                    end
                end
            end
            for (int c = 0; c < NUM_COMP; c++) begin
                if (done_cnt[c] > 0) begin
                    done_cnt[c]--;
                    if (done_cnt[c] == 0) begin
                        done_nxt[c] = 1'b1;
                    end
                end
            end
            @(posedge clk);
            #1;
            ahb_rsp.hready = rdy_nxt;
            ahb_rsp.hgrant = gnt_nxt;
            ahb_rsp.hrdata = (dp_valid && !dp_write) ? mem[word_index(dp_addr)] : '0;
            comp_done      = done_nxt;
        end
    end

    // ------------------------------------------------------------
    // test table and checks
    // ------------------------------------------------------------
    task automatic add_row(input string name, input logic [31:0] src, input logic [31:0] dst,
                           input int n, input logic [NUM_COMP-1:0] fail, input bit stall);
        names[num_rows] = name;
        rows[num_rows]  = '{src: src, dst: dst, len: BLK_CNT_W'(n), fail: fail, stall: stall};
        num_rows++;
    endtask

    task automatic load_table();
        num_rows = 0;
        add_row("one_block",      32'h0000, 32'h2000, 1, 3'b000, 1'b0);
        add_row("c0_fails",       32'h0100, 32'h2100, 1, 3'b001, 1'b0);
        add_row("c0_c1_fail",     32'h0200, 32'h2200, 1, 3'b011, 1'b0);
        add_row("c1_c2_fail",     32'h0300, 32'h2300, 1, 3'b110, 1'b0);
        add_row("all_fail",       32'h0400, 32'h2400, 1, 3'b111, 1'b0);
        add_row("three_blocks",   32'h0800, 32'h2800, 3, 3'b000, 1'b0);
        add_row("zero_length",    32'h0c00, 32'h2c00, 0, 3'b000, 1'b0);
        add_row("stall_three",    32'h1000, 32'h3000, 3, 3'b001, 1'b1);
        add_row("stall_owner",    32'h1400, 32'h3400, 2, 3'b110, 1'b1);
        add_row("stall_all_fail", 32'h1800, 32'h3800, 1, 3'b111, 1'b1);
    endtask

    task automatic report_value(input string what, input logic [63:0] expv,
                                input logic [63:0] actv);
        errors++;
        test_errs++;
        if (err_lines < MAX_LINES) begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_name, what, expv, actv);
            err_lines++;
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        test_errs++;
        $display("%s: %s", cur_name, what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_one(input int t);
        test_row_t   row;
        int          cycles;
        int          budget;
        int          own;
        int          idx;
        logic [63:0] expw;
        logic [63:0] bw;
        row       = rows[t];
        cur_name  = names[t];
        test_errs = 0;
        err_lines = 0;
        next_cycle();
        src_addr  = row.src;
        dst_addr  = row.dst;
        len       = row.len;
        comp_fail = row.fail;
        stall_en  = row.stall;
        rec_data.delete();
        rec_sop.delete();
        rec_eop.delete();
        blocks_seen = 0;
        req_seen    = 1'b0;
        range_errs  = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            snap[i] = mem[i];
        end
        next_cycle();
        start = 1'b1;
        #2;
        if (done !== 1'b0) begin
            report_value("done_o during start", 64'(0), 64'(done));
        end
        next_cycle();
        start = 1'b0;
        if (row.len == '0) begin
            for (int i = 0; i < 30; i++) begin
                #2;
                if (done !== 1'b1) begin
                    report_value("done_o after zero length start", 64'(1), 64'(done));
                end
                next_cycle();
            end
            if (req_seen) begin
                report_problem("bus request raised for a zero length start");
            end
        end else begin
            budget = BLK_TIMEOUT * int'(row.len) + 200;
            cycles = 0;
            #2;
            while (done !== 1'b1 && cycles < budget) begin
                next_cycle();
                #2;
                cycles++;
            end
            if (done !== 1'b1) begin
                report_problem("timed out waiting for done_o");
                timed_out = 1'b1;
            end
        end
        if (range_errs != 0) begin
            report_problem("bus access outside the memory model");
        end
        // compressor input words, even beat in the upper half
        if (rec_data.size() != 16 * int'(row.len)) begin
            report_value("word count", 64'(16 * int'(row.len)), 64'(rec_data.size()));
        end else begin
            for (int b = 0; b < int'(row.len); b++) begin
                for (int w = 0; w < WORDS_PER_BLK; w++) begin
                    idx  = word_index(row.src + 32'(b * BLK_RD_BYTES) + 32'(w * 8));
                    expw = {snap[idx], snap[idx + 1]};
                    if (rec_data[b * 16 + w] !== expw) begin
                        report_value($sformatf("block %0d word %0d", b, w), expw,
                                     rec_data[b * 16 + w]);
                    end
                    if (rec_sop[b * 16 + w] !== (w == 0)) begin
                        report_value($sformatf("block %0d word %0d start mark", b, w),
                                     64'(w == 0), 64'(rec_sop[b * 16 + w]));
                    end
                    if (rec_eop[b * 16 + w] !== (w == 15)) begin
                        report_value($sformatf("block %0d word %0d end mark", b, w),
                                     64'(w == 15), 64'(rec_eop[b * 16 + w]));
                    end
                end
            end
        end
        // destination image, everything else unchanged
        for (int i = 0; i < MEM_WORDS; i++) begin
            exp_mem[i] = snap[i];
        end
        own = owner_of(row.fail);
        for (int b = 0; b < int'(row.len); b++) begin
            for (int k = 0; k < BURST_BEATS; k++) begin
                bw  = buf_word(own, b, 3'(k / 2));
                idx = word_index(row.dst + 32'(b * BLK_WR_BYTES) + 32'(k * BEAT_BYTES));
                exp_mem[idx] = (k % 2 == 1) ? bw[31:0] : bw[63:32];
            end
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (mem[i] !== exp_mem[i]) begin
                report_value($sformatf("memory at %h", i * 4), 64'(exp_mem[i]), 64'(mem[i]));
            end
        end
        $display("test %0d %s: %s, %0d errors", t, cur_name,
                 (test_errs == 0) ? "ok" : "mismatch", test_errs);
    endtask

    initial begin : run_tests
        int tests_run;
        int tests_ok;
        int errs_before;
        void'($urandom(79));
        rst_n      = 1'b0;
        start      = 1'b0;
        src_addr   = '0;
        dst_addr   = '0;
        len        = '0;
        comp_fail  = '0;
        stall_en   = 1'b0;
        errors     = 0;
        timed_out  = 1'b0;
        comp_blk   = 0;
        tests_run  = 0;
        tests_ok   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $urandom;
        end
        load_table();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < num_rows && !timed_out; t++) begin
            errs_before = errors;
            run_one(t);
            tests_run++;
            if (errors == errs_before) begin
                tests_ok++;
            end
        end
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

// File: hdl/comp_engine_top.sv
module comp_engine_top
    import ahb_pkg::*;
    import comp_pkg::*;
#(
    parameter int NUM_COMP  = 3,
    parameter int BLK_CNT_W = 25
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      start_i,
    output logic                      done_o,
    input  logic [31:0]               src_addr_i,
    input  logic [31:0]               dst_addr_i,
    input  logic [BLK_CNT_W-1:0]      len_i,

    output ahb_req_t                  ahb_o,
    input  ahb_rsp_t                  ahb_i,

    output comp_word_t                comp_o,
    input  logic [NUM_COMP-1:0]       comp_done_i,
    input  logic [NUM_COMP-1:0]       comp_fail_i,
    output logic [BUF_ADDR_W-1:0]     buf_addr_o,
    input  logic [NUM_COMP-1:0][63:0] comp_rdata_i
);

    localparam int BEAT_W = $clog2(BURST_BEATS);

    // sequencer to burst master
    logic              burst_go;
    logic [31:0]       burst_addr;
    logic              burst_write;
    logic              burst_second;
    logic              burst_done;

    // read beats, write beats
    logic              rd_beat;
    logic [BEAT_W:0]   rd_idx;
    logic [BEAT_W-1:0] wr_idx;
    logic [31:0]       wr_data;

    logic              sel_capture;
    logic              comp_all_done;

    assign comp_all_done = &comp_done_i;

    block_sequencer #(
        .BLK_CNT_W (BLK_CNT_W)
    ) u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start_i),
        .len_i           (len_i),
        .src_addr_i      (src_addr_i),
        .dst_addr_i      (dst_addr_i),
        .burst_done_i    (burst_done),
        .comp_all_done_i (comp_all_done),
        .done_o          (done_o),
        .burst_go_o      (burst_go),
        .burst_addr_o    (burst_addr),
        .burst_write_o   (burst_write),
        .second_o        (burst_second),
        .sel_capture_o   (sel_capture)
    );

    ahb_burst_master u_mst (
        .clk       (clk),
        .rst_n     (rst_n),
        .go_i      (burst_go),
        .addr_i    (burst_addr),
        .write_i   (burst_write),
        .second_i  (burst_second),
        .wdata_i   (wr_data),
        .ahb_i     (ahb_i),
        .ahb_o     (ahb_o),
        .done_o    (burst_done),
        .rd_beat_o (rd_beat),
        .rd_idx_o  (rd_idx),
        .wr_idx_o  (wr_idx)
    );

    beat_packer u_pack (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat_i  (rd_beat),
        .idx_i   (rd_idx),
        .rdata_i (ahb_i.hrdata),
        .word_o  (comp_o)
    );

    result_select #(
        .NUM_COMP (NUM_COMP)
    ) u_sel (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture_i  (sel_capture),
        .fail_i     (comp_fail_i),
        .rdata_i    (comp_rdata_i),
        .wr_idx_i   (wr_idx),
        .buf_addr_o (buf_addr_o),
        .wdata_o    (wr_data)
    );

endmodule

// File: hdl/result_select.sv
module result_select
    import comp_pkg::*;
#(
    parameter int NUM_COMP = 3
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           capture_i,
    input  logic [NUM_COMP-1:0]            fail_i,
    input  logic [NUM_COMP-1:0][63:0]      rdata_i,
    input  logic [BUF_ADDR_W:0]            wr_idx_i,
    output logic [BUF_ADDR_W-1:0]          buf_addr_o,
    output logic [31:0]                    wdata_o
);

    localparam int OWN_W = (NUM_COMP > 1) ? $clog2(NUM_COMP) : 1;

    logic [OWN_W-1:0] pick;
    logic [OWN_W-1:0] owner_q;
    logic [63:0]      owner_word;

    // lowest passing compressor wins, 0 when every one failed
    always_comb begin
        pick = '0;
        for (int i = NUM_COMP - 1; i >= 0; i--) begin
            if (!fail_i[i]) begin
                pick = OWN_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q <= '0;
        end else if (capture_i) begin
            owner_q <= pick;
        end
    end

    // ------------------------------------------------------------
    // buffer read, two beats per entry
    // ------------------------------------------------------------
    assign owner_word = rdata_i[owner_q];
    assign buf_addr_o = wr_idx_i[BUF_ADDR_W:1];
    assign wdata_o    = wr_idx_i[0] ? owner_word[31:0] : owner_word[63:32];

    a_owner_range: assert property (@(posedge clk) disable iff (!rst_n)
        owner_q < NUM_COMP);

endmodule

// File: hdl/beat_packer.sv
module beat_packer
    import ahb_pkg::*;
    import comp_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         beat_i,
    input  logic [$clog2(BURST_BEATS):0] idx_i,
    input  logic [31:0]                  rdata_i,
    output comp_word_t                   word_o
);

    localparam int IDX_W = $clog2(BURST_BEATS) + 1;
    localparam logic [IDX_W-2:0] LAST_WORD = (IDX_W-1)'(WORDS_PER_BLK - 1);

    logic        odd_beat;
    logic        wren_q;
    logic        sop_q;
    logic        eop_q;
    logic [63:0] data_q;

    assign odd_beat = beat_i && idx_i[0];

    // an odd beat completes a word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wren_q <= 1'b0;
            sop_q  <= 1'b0;
            eop_q  <= 1'b0;
        end else begin
            wren_q <= odd_beat;
            sop_q  <= odd_beat && (idx_i[IDX_W-1:1] == '0);
            eop_q  <= odd_beat && (idx_i[IDX_W-1:1] == LAST_WORD);
        end
    end

    // even beat to the upper half, odd beat to the lower
    always_ff @(posedge clk) begin
        if (beat_i) begin
            if (idx_i[0]) begin
                data_q[31:0] <= rdata_i;
            end else begin
                data_q[63:32] <= rdata_i;
            end
        end
    end

    assign word_o = '{
        wren: wren_q,
        sop:  sop_q,
        eop:  eop_q,
        data: data_q
    };

endmodule

// File: hdl/ahb_burst_master.sv
module ahb_burst_master
    import ahb_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           go_i,
    input  logic [31:0]                    addr_i,
    input  logic                           write_i,
    input  logic                           second_i,
    input  logic [31:0]                    wdata_i,
    input  ahb_rsp_t                       ahb_i,
    output ahb_req_t                       ahb_o,
    output logic                           done_o,
    output logic                           rd_beat_o,
    output logic [$clog2(BURST_BEATS):0]   rd_idx_o,
    output logic [$clog2(BURST_BEATS)-1:0] wr_idx_o
);

    localparam int BEAT_W = $clog2(BURST_BEATS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_BEATS - 1);

    // ------------------------------------------------------------
    // address phase: | 0 | 1 | 2 | ... |14 |15 |
    // data phase   :     | 0 | 1 | ... |13 |14 |15 |
    // state        : ADDR1 |    MID            |LAST
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_ADDR1,
        ST_MID,
        ST_LAST
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic              busreq_q;
    logic              busreq_d;
    logic [31:0]       haddr_q;
    logic [31:0]       haddr_d;
    htrans_e           htrans_q;
    htrans_e           htrans_d;
    logic              hwrite_q;
    logic              hwrite_d;
    logic [31:0]       hwdata_q;
    logic [31:0]       hwdata_d;
    // accepted address phases and data phases
    logic [BEAT_W-1:0] addr_cnt_q;
    logic [BEAT_W-1:0] addr_cnt_d;
    logic [BEAT_W-1:0] data_cnt_q;
    logic [BEAT_W-1:0] data_cnt_d;
    logic              second_q;
    logic              second_d;

    always_comb begin
        state_d    = state_q;
        busreq_d   = busreq_q;
        haddr_d    = haddr_q;
        htrans_d   = htrans_q;
        hwrite_d   = hwrite_q;
        hwdata_d   = hwdata_q;
        addr_cnt_d = addr_cnt_q;
        data_cnt_d = data_cnt_q;
        second_d   = second_q;
        case (state_q)
            ST_IDLE: begin
                if (go_i) begin
                    busreq_d = 1'b1;
                    haddr_d  = addr_i;
                    hwrite_d = write_i;
                    second_d = second_i;
                    state_d  = ST_REQ;
                end
            end
            ST_REQ: begin
                // hold the request until granted
                if (ahb_i.hgrant) begin
                    htrans_d   = HTRANS_NONSEQ;
                    addr_cnt_d = '0;
                    state_d    = ST_ADDR1;
                end
            end
            ST_ADDR1: begin
                if (ahb_i.hready) begin
                    haddr_d    = haddr_q + BEAT_BYTES;
                    htrans_d   = HTRANS_SEQ;
                    addr_cnt_d = addr_cnt_q + 1'b1;
                    data_cnt_d = '0;
                    if (hwrite_q) begin
                        hwdata_d = wdata_i;
                    end
                    state_d    = ST_MID;
                end
            end
            ST_MID: begin
                if (ahb_i.hready) begin
                    data_cnt_d = data_cnt_q + 1'b1;
                    if (hwrite_q) begin
                        hwdata_d = wdata_i;
                    end
                    // release the bus two beats ahead of the end
                    if (addr_cnt_q == LAST_BEAT - 1'b1) begin
                        busreq_d = 1'b0;
                    end
                    if (addr_cnt_q == LAST_BEAT) begin
                        htrans_d = HTRANS_IDLE;
                        state_d  = ST_LAST;
                    end else begin
                        haddr_d    = haddr_q + BEAT_BYTES;
                        addr_cnt_d = addr_cnt_q + 1'b1;
                    end
                end
            end
            default: begin
                if (ahb_i.hready) begin
                    state_d = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            busreq_q   <= 1'b0;
            haddr_q    <= '0;
            htrans_q   <= HTRANS_IDLE;
            hwrite_q   <= 1'b0;
            addr_cnt_q <= '0;
            data_cnt_q <= '0;
            second_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            busreq_q   <= busreq_d;
            haddr_q    <= haddr_d;
            htrans_q   <= htrans_d;
            hwrite_q   <= hwrite_d;
            addr_cnt_q <= addr_cnt_d;
            data_cnt_q <= data_cnt_d;
            second_q   <= second_d;
        end
    end

    always_ff @(posedge clk) begin
        hwdata_q <= hwdata_d;
    end

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------
    assign ahb_o = '{
        hbusreq: busreq_q,
        haddr:   haddr_q,
        htrans:  htrans_q,
        hwrite:  hwrite_q,
        hwdata:  hwdata_q
    };

    assign done_o    = (state_q == ST_LAST) && ahb_i.hready;
    assign rd_beat_o = !hwrite_q && ahb_i.hready
                       && (state_q == ST_MID || state_q == ST_LAST);
    // second burst continues the index from 16
    assign rd_idx_o  = {second_q, data_cnt_q};
    assign wr_idx_o  = addr_cnt_q;

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(ahb_o.haddr) |-> $past(ahb_i.hready || go_i));

    a_no_idle_seq: assert property (@(posedge clk) disable iff (!rst_n)
        (ahb_o.htrans == HTRANS_IDLE) |=> (ahb_o.htrans != HTRANS_SEQ));

endmodule

// File: hdl/block_sequencer.sv
module block_sequencer
    import ahb_pkg::*;
#(
    parameter int BLK_CNT_W = 25
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic [BLK_CNT_W-1:0] len_i,
    input  logic [31:0]          src_addr_i,
    input  logic [31:0]          dst_addr_i,
    input  logic                 burst_done_i,
    input  logic                 comp_all_done_i,
    output logic                 done_o,
    output logic                 burst_go_o,
    output logic [31:0]          burst_addr_o,
    output logic                 burst_write_o,
    output logic                 second_o,
    output logic                 sel_capture_o
);

    // offset of the second read burst inside a block
    localparam logic [31:0] HALF_OFS = 32'(BURST_BEATS * BEAT_BYTES);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_RD1,
        PH_RD2,
        PH_COMP,
        PH_WR
    } phase_e;

    phase_e               phase_q;
    phase_e               phase_d;
    logic [BLK_CNT_W-1:0] blk_q;
    logic [BLK_CNT_W-1:0] blk_d;
    logic [BLK_CNT_W-1:0] blk_inc;
    logic                 go_d;
    logic                 write_d;
    logic [31:0]          addr_d;
    logic [31:0]          rd_base;
    logic [31:0]          next_base;
    logic [31:0]          wr_base;

    assign blk_inc   = blk_q + 1'b1;
    assign rd_base   = src_addr_i + 32'(blk_q) * BLK_RD_BYTES;
    assign next_base = src_addr_i + 32'(blk_inc) * BLK_RD_BYTES;
    assign wr_base   = dst_addr_i + 32'(blk_q) * BLK_WR_BYTES;

    // ------------------------------------------------------------
    // phase control
    // ------------------------------------------------------------
    always_comb begin
        phase_d = phase_q;
        blk_d   = blk_q;
        go_d    = 1'b0;
        write_d = burst_write_o;
        addr_d  = burst_addr_o;
        case (phase_q)
            PH_IDLE: begin
                // zero length is ignored
                if (start_i && len_i != '0) begin
                    blk_d   = '0;
                    go_d    = 1'b1;
                    write_d = 1'b0;
                    addr_d  = src_addr_i;
                    phase_d = PH_RD1;
                end
            end
            PH_RD1: begin
                if (burst_done_i) begin
                    go_d    = 1'b1;
                    addr_d  = rd_base + HALF_OFS;
                    phase_d = PH_RD2;
                end
            end
            PH_RD2: begin
                if (burst_done_i) begin
                    phase_d = PH_COMP;
                end
            end
            PH_COMP: begin
                if (comp_all_done_i) begin
                    go_d    = 1'b1;
                    write_d = 1'b1;
                    addr_d  = wr_base;
                    phase_d = PH_WR;
                end
            end
            default: begin
                if (burst_done_i) begin
                    if (blk_inc == len_i) begin
                        phase_d = PH_IDLE;
                    end else begin
                        // straight on to the next block
                        blk_d   = blk_inc;
                        go_d    = 1'b1;
                        write_d = 1'b0;
                        addr_d  = next_base;
                        phase_d = PH_RD1;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q       <= PH_IDLE;
            blk_q         <= '0;
            burst_go_o    <= 1'b0;
            burst_write_o <= 1'b0;
        end else begin
            phase_q       <= phase_d;
            blk_q         <= blk_d;
            burst_go_o    <= go_d;
            burst_write_o <= write_d;
        end
    end

    always_ff @(posedge clk) begin
        burst_addr_o <= addr_d;
    end

    // start is masked so a status poll never sees a stale done
    assign done_o        = (phase_q == PH_IDLE) && !start_i;
    assign second_o      = (phase_q == PH_RD2);
    assign sel_capture_o = (phase_q == PH_COMP) && comp_all_done_i;

    // no new burst until the master reports the current one finished
    a_no_go_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
        burst_go_o |=> (!burst_go_o until_with burst_done_i));

endmodule

// File: hdl/comp_pkg.sv
package comp_pkg;

    // word streamed to the compressors
    typedef struct packed {
        logic        wren;
        logic        sop;
        logic        eop;
        logic [63:0] data;
    } comp_word_t;

    // 128-byte block as 64-bit words
    localparam int unsigned WORDS_PER_BLK = 16;

    // result buffer holds 64 bytes, eight 64-bit entries
    localparam int unsigned BUF_ADDR_W    = 3;

endpackage

// File: hdl/ahb_pkg.sv
package ahb_pkg;

    // ------------------------------------------------------------
    // transfer encodings
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // ------------------------------------------------------------
    // burst geometry
    // ------------------------------------------------------------
    // every transfer is a 4-byte INCR16 beat
    localparam int unsigned BURST_BEATS  = 16;
    localparam int unsigned BEAT_BYTES   = 4;

    // source block is read as two bursts, result written as one
    localparam int unsigned BLK_RD_BYTES = 128;
    localparam int unsigned BLK_WR_BYTES = 64;

    // master-side request
    typedef struct packed {
        logic        hbusreq;
        logic [31:0] haddr;
        htrans_e     htrans;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    // master-side response
    typedef struct packed {
        logic        hgrant;
        logic        hready;
        logic [31:0] hrdata;
    } ahb_rsp_t;

endpackage
